// ==== design/alu.sv ====
/*
 * integer alu for one lane with single cycle base ops
 * multiplies go through an owned iterative multiplier and hold the lane occupied
 */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module alu (
	input  logic               clock,
	input  logic               reset,
	input  logic               valid_in, // one-cycle issue strobe
	input  logic               lq_cdb_valid, // load queue owns the cdb this cycle
	input  logic [`XLEN-1:0]   opa,
	input  logic [`XLEN-1:0]   opb,
	input  ex_pkg::alu_func_e  func,
	output logic               occupied,
	output logic               valid_out,
	output logic [`XLEN-1:0]   result
);

	ex_pkg::alu_state_e state, next_state;

	logic                 is_mult;
	logic                 start;
	logic [1:0]           sign; // mult sign bits per operand
	logic                 hi_sel, hi_sel_q; // upper product half wanted
	logic [2*`XLEN-1:0]   product;
	logic                 mult_done;
	logic [`XLEN-1:0]     int_result;
	logic [`XLEN-1:0]     mult_result;

	assign is_mult = (func == ex_pkg::ALU_MUL) || (func == ex_pkg::ALU_MULH) ||
		(func == ex_pkg::ALU_MULHSU) || (func == ex_pkg::ALU_MULHU);

	mult u_mult (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.sign    (sign),
		.mcand   (opa),
		.mplier  (opb),
		.product (product),
		.done    (mult_done)
	);

	//////////////////////////////////////////////////
	// combinational ops and mult decode
	//////////////////////////////////////////////////
	always_comb begin
		int_result = '0;
		sign       = 2'b00;
		hi_sel     = 1'b0;
		case (func)
			ex_pkg::ALU_ADD:  int_result = opa + opb;
			ex_pkg::ALU_SUB:  int_result = opa - opb;
			ex_pkg::ALU_SLT:  int_result = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ex_pkg::ALU_SLTU: int_result = {{(`XLEN-1){1'b0}}, opa < opb};
			ex_pkg::ALU_AND:  int_result = opa & opb;
			ex_pkg::ALU_OR:   int_result = opa | opb;
			ex_pkg::ALU_XOR:  int_result = opa ^ opb;
			ex_pkg::ALU_SLL:  int_result = opa << opb[4:0];
			ex_pkg::ALU_SRL:  int_result = opa >> opb[4:0];
			ex_pkg::ALU_SRA:  int_result = $signed(opa) >>> opb[4:0]; // keeps sign bit
			ex_pkg::ALU_MUL:    sign = 2'b11; // low half
			ex_pkg::ALU_MULH: begin
				sign   = 2'b11;
				hi_sel = 1'b1;
			end
			ex_pkg::ALU_MULHSU: begin
				sign   = 2'b01; // signed rs1 by unsigned rs2
				hi_sel = 1'b1;
			end
			ex_pkg::ALU_MULHU:  hi_sel = 1'b1;
			default:            int_result = '0; // unused codes
		endcase
	end

	assign mult_result = hi_sel_q ? product[2*`XLEN-1:`XLEN] : product[`XLEN-1:0];
	assign result      = occupied ? mult_result : int_result;

	//////////////////////////////////////////////////
	// lane FSM
	//////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		valid_out  = 1'b0;
		start      = 1'b0;
		case (state)
			ex_pkg::ALU_IDLE:
				if (valid_in && !lq_cdb_valid) begin // nothing accepted while the bus is taken
					if (is_mult) begin
						start      = 1'b1;
						next_state = ex_pkg::ALU_MULT_WAIT;
					end else begin
						valid_out = 1'b1; // same-cycle result
					end
				end
			ex_pkg::ALU_MULT_WAIT:
				if (mult_done && !lq_cdb_valid) begin
					valid_out  = 1'b1;
					next_state = ex_pkg::ALU_IDLE;
				end
			default: next_state = ex_pkg::ALU_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ex_pkg::ALU_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clock) begin
		if (start) hi_sel_q <= hi_sel; // held for the whole multiply
	end

	assign occupied = (state == ex_pkg::ALU_MULT_WAIT);

	a_cdb_stall: assert property (@(posedge clock) disable iff (reset)
		valid_out |-> !lq_cdb_valid)
		else $error("alu: valid_out while the load queue holds the cdb");

	// fixed multiplier latency seen from the issuing edge
	a_mult_latency: assert property (@(posedge clock) disable iff (reset)
		start |=> !mult_done [*`MULT_CYCLES] ##1 mult_done)
		else $error("alu: multiply did not finish on time");

endmodule

// ==== design/ex_cfg.svh ====
/*
 * global sizing for the execute stage
 * include wherever a width, the lane count or the multiplier step is needed
 */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath
`define XLEN 32 // rv32 register width
`define WAYS 2 // parallel execute lanes

// iterative multiplier
`define MULT_STEP 8 // mplier bits retired per cycle
`define MULT_CYCLES ((2 * `XLEN) / `MULT_STEP) // steps for a full 2*xlen product

// encoded widths of the control enums, also used for the flattened top ports
`define ALU_FUNC_W 4
`define OPA_SEL_W 2
`define OPB_SEL_W 3
`define ALU_STATE_W 1

`endif

// ==== design/ex_lane.sv ====
/*
 * one execute lane: operand muxes, rv32 immediate extraction, branch test
 * and the alu with its multiplier, all inputs come straight from issue
 */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_lane (
	input  logic               clock,
	input  logic               reset,
	input  logic               valid,
	input  logic               lq_cdb_valid,
	input  ex_pkg::alu_func_e  alu_func,
	input  ex_pkg::opa_sel_e   opa_select,
	input  ex_pkg::opb_sel_e   opb_select,
	input  logic [`XLEN-1:0]   inst,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   npc,
	input  logic [`XLEN-1:0]   rs1_value,
	input  logic [`XLEN-1:0]   rs2_value,
	input  logic               cond_branch,
	input  logic               uncond_branch,
	output logic               valid_out,
	output logic [`XLEN-1:0]   alu_result,
	output logic               take_branch,
	output logic               occupied
);

	// branch funct3 codes
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	logic [`XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
	logic [`XLEN-1:0] opa_mux, opb_mux;
	logic [2:0]       funct3;
	logic             br_cond;

	//////////////////////////////////////////////////
	// immediates, sign bit is always inst[31]
	//////////////////////////////////////////////////
	assign i_imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign s_imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
		inst[11:8], 1'b0}; // halfword aligned
	assign u_imm = {inst[31:12], 12'b0}; // upper 20, no extension needed
	assign j_imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
		inst[30:21], 1'b0};

	//////////////////////////////////////////////////
	// operand muxes
	//////////////////////////////////////////////////
	always_comb begin
		case (opa_select)
			ex_pkg::OPA_IS_RS1:  opa_mux = rs1_value;
			ex_pkg::OPA_IS_NPC:  opa_mux = npc;
			ex_pkg::OPA_IS_PC:   opa_mux = pc;
			ex_pkg::OPA_IS_ZERO: opa_mux = '0;
			default:             opa_mux = '0;
		endcase
	end

	always_comb begin
		case (opb_select)
			ex_pkg::OPB_IS_RS2:   opb_mux = rs2_value;
			ex_pkg::OPB_IS_I_IMM: opb_mux = i_imm; // alu-imm, loads, jalr
			ex_pkg::OPB_IS_S_IMM: opb_mux = s_imm; // stores
			ex_pkg::OPB_IS_B_IMM: opb_mux = b_imm; // branch target
			ex_pkg::OPB_IS_U_IMM: opb_mux = u_imm; // lui, auipc
			ex_pkg::OPB_IS_J_IMM: opb_mux = j_imm; // jal target
			default:              opb_mux = '0; // illegal select
		endcase
	end

	//////////////////////////////////////////////////
	// branch condition
	//////////////////////////////////////////////////
	assign funct3 = inst[14:12];

	always_comb begin
		case (funct3)
			F3_BEQ:  br_cond = (rs1_value == rs2_value);
			F3_BNE:  br_cond = (rs1_value != rs2_value);
			F3_BLT:  br_cond = ($signed(rs1_value) <  $signed(rs2_value));
			F3_BGE:  br_cond = ($signed(rs1_value) >= $signed(rs2_value));
			F3_BLTU: br_cond = (rs1_value <  rs2_value);
			F3_BGEU: br_cond = (rs1_value >= rs2_value);
			default: br_cond = 1'b0; // 010 and 011 are not branches
		endcase
	end

	// jumps always taken, branches only on a true condition
	assign take_branch = uncond_branch | (cond_branch & br_cond);

	alu u_alu (
		.clock        (clock),
		.reset        (reset),
		.valid_in     (valid),
		.lq_cdb_valid (lq_cdb_valid),
		.opa          (opa_mux),
		.opb          (opb_mux),
		.func         (alu_func),
		.occupied     (occupied),
		.valid_out    (valid_out),
		.result       (alu_result)
	);

	// decode must never issue one of the two spare opb codes
	a_opb_legal: assert property (@(posedge clock) disable iff (reset)
		valid |-> opb_select inside {ex_pkg::OPB_IS_RS2, ex_pkg::OPB_IS_I_IMM,
			ex_pkg::OPB_IS_S_IMM, ex_pkg::OPB_IS_B_IMM,
			ex_pkg::OPB_IS_U_IMM, ex_pkg::OPB_IS_J_IMM})
		else $error("ex_lane: illegal opb_select on a valid instruction");

endmodule

// ==== design/ex_pkg.sv ====
/*
 * enum types shared by the execute stage RTL
 * alu function codes, operand selects and the lane FSM states
 */
`include "ex_cfg.svh"

package ex_pkg;

	//////////////////////////////////////////////////
	// alu function codes
	//////////////////////////////////////////////////
	typedef enum logic [`ALU_FUNC_W-1:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2, // signed compare
		ALU_SLTU   = 4'h3, // unsigned compare
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9, // arithmetic right
		ALU_MUL    = 4'ha, // low half, s x s
		ALU_MULH   = 4'hb, // high half, s x s
		ALU_MULHSU = 4'hc, // high half, s x u
		ALU_MULHU  = 4'hd  // high half, u x u
	} alu_func_e;

	//////////////////////////////////////////////////
	// operand selects
	//////////////////////////////////////////////////
	typedef enum logic [`OPA_SEL_W-1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_e;

	typedef enum logic [`OPB_SEL_W-1:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5 // 6 and 7 unused
	} opb_sel_e;

	// lane FSM, only multiplies ever leave idle
	typedef enum logic [`ALU_STATE_W-1:0] {
		ALU_IDLE      = 1'b0,
		ALU_MULT_WAIT = 1'b1
	} alu_state_e;

endpackage

// ==== design/ex_stage.sv ====
/*
 * superscalar execute stage top, WAYS independent lanes
 * every port is flattened, lane i owns slice i of each vector
 */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [`WAYS-1:0]                 valid,
	input  logic [`WAYS*`ALU_FUNC_W-1:0]     alu_func,
	input  logic [`WAYS*`OPA_SEL_W-1:0]      opa_select,
	input  logic [`WAYS*`OPB_SEL_W-1:0]      opb_select,
	input  logic [`WAYS*`XLEN-1:0]           inst,
	input  logic [`WAYS*`XLEN-1:0]           pc,
	input  logic [`WAYS*`XLEN-1:0]           npc,
	input  logic [`WAYS*`XLEN-1:0]           rs1_value,
	input  logic [`WAYS*`XLEN-1:0]           rs2_value,
	input  logic [`WAYS-1:0]                 cond_branch,
	input  logic [`WAYS-1:0]                 uncond_branch,
	input  logic [`WAYS-1:0]                 lq_cdb_valid, // per-lane bus stall
	output logic [`WAYS-1:0]                 valid_out,
	output logic [`WAYS*`XLEN-1:0]           alu_result,
	output logic [`WAYS-1:0]                 take_branch,
	output logic [`WAYS-1:0]                 occupied // lane busy with a multiply
);

	//////////////////////////////////////////////////
	// lanes
	//////////////////////////////////////////////////
	for (genvar i = 0; i < `WAYS; i++) begin : g_lane
		ex_lane u_lane (
			.clock         (clock),
			.reset         (reset),
			.valid         (valid[i]),
			.lq_cdb_valid  (lq_cdb_valid[i]),
			.alu_func      (ex_pkg::alu_func_e'(alu_func[i*`ALU_FUNC_W +: `ALU_FUNC_W])),
			.opa_select    (ex_pkg::opa_sel_e'(opa_select[i*`OPA_SEL_W +: `OPA_SEL_W])),
			.opb_select    (ex_pkg::opb_sel_e'(opb_select[i*`OPB_SEL_W +: `OPB_SEL_W])),
			.inst          (inst[i*`XLEN +: `XLEN]),
			.pc            (pc[i*`XLEN +: `XLEN]),
			.npc           (npc[i*`XLEN +: `XLEN]),
			.rs1_value     (rs1_value[i*`XLEN +: `XLEN]),
			.rs2_value     (rs2_value[i*`XLEN +: `XLEN]),
			.cond_branch   (cond_branch[i]),
			.uncond_branch (uncond_branch[i]),
			.valid_out     (valid_out[i]),
			.alu_result    (alu_result[i*`XLEN +: `XLEN]),
			.take_branch   (take_branch[i]),
			.occupied      (occupied[i])
		);
	end

endmodule

// ==== design/mult.sv ====
/*
 * iterative shift-add multiplier, MULT_STEP mplier bits per cycle
 * pulse start with stable operands, product is valid and held while done is high
 */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module mult (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start, // one-cycle pulse
	input  logic [1:0]            sign, // [0] mcand signed, [1] mplier signed
	input  logic [`XLEN-1:0]      mcand,
	input  logic [`XLEN-1:0]      mplier,
	output logic [2*`XLEN-1:0]    product,
	output logic                  done
);

	localparam int PW = 2 * `XLEN; // full product width
	localparam int CW = $clog2(`MULT_CYCLES);
	localparam logic [CW-1:0] LAST = CW'(`MULT_CYCLES - 1);

	logic [PW-1:0] mcand_ext, mplier_ext; // operands widened per sign bit
	logic [PW-1:0] mcand_r, mplier_r; // shifting copies
	logic [PW-1:0] acc; // running partial sum
	logic [PW-1:0] step_prod; // this cycle's partial product
	logic [CW-1:0] count;
	logic          running;

	// sign or zero extend both operands to the product width
	assign mcand_ext  = {{`XLEN{sign[0] & mcand[`XLEN-1]}}, mcand};
	assign mplier_ext = {{`XLEN{sign[1] & mplier[`XLEN-1]}}, mplier};

	// mcand times the low step bits, mod 2^PW so signed extension works out
	assign step_prod = mcand_r * {{(PW - `MULT_STEP){1'b0}}, mplier_r[`MULT_STEP-1:0]};

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			done    <= 1'b0;
			count   <= '0;
		end else if (start) begin
			running <= 1'b1;
			done    <= 1'b0; // drops until the new product is ready
			count   <= '0;
		end else if (running) begin
			count <= count + 1'b1;
			if (count == LAST) begin
				running <= 1'b0;
				done    <= 1'b1; // sticky until next start
			end
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (start) begin
			mcand_r  <= mcand_ext;
			mplier_r <= mplier_ext;
			acc      <= '0;
		end else if (running) begin
			acc      <= acc + step_prod;
			mcand_r  <= mcand_r << `MULT_STEP; // next weight
			mplier_r <= mplier_r >> `MULT_STEP; // next digit down
		end
	end

	assign product = acc; // frozen once running drops

	// the alu FSM must never restart a multiply in flight
	a_no_restart: assert property (@(posedge clock) disable iff (reset)
		start |-> !running)
		else $error("mult: start while a multiply is running");

endmodule

// ==== ex_stage.f ====
+incdir+design
design/ex_pkg.sv
design/mult.sv
design/alu.sv
design/ex_lane.sv
design/ex_stage.sv
testbench/ex_stage_tb.sv

// ==== testbench/ex_stage_tb.sv ====
/*
 * testbench for the execute stage with LFSR operands checked against a reference model
 * per-lane expectations are queued at issue and checked by concurrent assertions
 */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_tb;

	localparam int FW = `ALU_FUNC_W;
	localparam int INT_REPS = 8;
	localparam int MULT_REPS = 8;
	localparam int MAX_WAIT = `MULT_CYCLES + 8; // cycles before a result counts as lost
	// summed test lengths in cycles
	localparam int LEN_TOTAL = 10 + 10 * INT_REPS * 3 + 24 * 3 + 20
		+ 4 * MULT_REPS * (`MULT_CYCLES + 4) + 2 * (`MULT_CYCLES + 12);
	localparam longint TIMEOUT_NS = 2 * LEN_TOTAL * 20; // doubled for margin

	logic                       clock, reset;
	logic [`WAYS-1:0]           valid, cond_branch, uncond_branch, lq_cdb_valid;
	logic [`WAYS*FW-1:0]        alu_func;
	logic [`WAYS*`OPA_SEL_W-1:0] opa_select;
	logic [`WAYS*`OPB_SEL_W-1:0] opb_select;
	logic [`WAYS*`XLEN-1:0]     inst, pc, npc, rs1_value, rs2_value;
	logic [`WAYS-1:0]           valid_out, take_branch, occupied;
	logic [`WAYS*`XLEN-1:0]     alu_result;

	logic [`XLEN-1:0] exp_q [`WAYS][$]; // outstanding results per lane
	string            name_q [`WAYS][$];
	logic [`XLEN-1:0] exp_head [`WAYS]; // head copies for the assertions
	string            name_head [`WAYS];
	logic [`WAYS-1:0] exp_pending, br_check, exp_br, fired;
	logic [31:0]      lfsr = 32'd81961;
	int               value_errs, proto_errs;

	ex_stage uut (.*);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	// galois lfsr x^32+x^22+x^2+x+1 stepped once per bit
	function automatic logic [`XLEN-1:0] rand_bits(int n);
		logic [`XLEN-1:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[`XLEN-2:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic is_mult_code(logic [FW-1:0] f);
		return f inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU,
			ex_pkg::ALU_MULHU};
	endfunction

	function automatic void refresh_head(int ln);
		exp_pending[ln] = exp_q[ln].size() != 0;
		if (exp_pending[ln]) begin
			exp_head[ln]  = exp_q[ln][0];
			name_head[ln] = name_q[ln][0];
		end
	endfunction

	task automatic push_expect(int ln, logic [`XLEN-1:0] val, string nm);
		exp_q[ln].push_back(val);
		name_q[ln].push_back(nm);
		refresh_head(ln);
	endtask

	task automatic set_lane(int ln, logic [FW-1:0] f, logic [1:0] sa, logic [2:0] sb,
		logic [`XLEN-1:0] ins, logic [`XLEN-1:0] p, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b);
		alu_func[ln*FW +: FW]                 = f;
		opa_select[ln*`OPA_SEL_W +: `OPA_SEL_W] = sa;
		opb_select[ln*`OPB_SEL_W +: `OPB_SEL_W] = sb;
		inst[ln*`XLEN +: `XLEN]      = ins;
		pc[ln*`XLEN +: `XLEN]        = p;
		npc[ln*`XLEN +: `XLEN]       = p + 4; // sequential next pc
		rs1_value[ln*`XLEN +: `XLEN] = a;
		rs2_value[ln*`XLEN +: `XLEN] = b;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic issue(logic [`WAYS-1:0] mask);
		valid = mask;
		next_cycle();
		valid = '0; // one-cycle strobe
	endtask

	// wait for every queued result and flush the lost ones
	task automatic wait_idle(string nm);
		int n;
		int left;
		n = 0;
		left = 1;
		while (left != 0 && n < MAX_WAIT) begin
			left = 0;
			for (int k = 0; k < `WAYS; k++) left += exp_q[k].size();
			if (left != 0) next_cycle();
			n++;
		end
		for (int k = 0; k < `WAYS; k++) begin
			if (exp_q[k].size() != 0) begin
				proto_errs++;
				$display("%s: lane %0d never delivered its result", nm, k);
				exp_q[k].delete();
				name_q[k].delete();
				refresh_head(k);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic logic [`XLEN-1:0] alu_model(logic [FW-1:0] f, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b);
		logic [2*`XLEN-1:0] as, bs, az, bz; // sign and zero extended
		logic [4:0]         sh;
		as = {{`XLEN{a[`XLEN-1]}}, a};
		bs = {{`XLEN{b[`XLEN-1]}}, b};
		az = {{`XLEN{1'b0}}, a};
		bz = {{`XLEN{1'b0}}, b};
		sh = b[4:0];
		case (f)
			ex_pkg::ALU_ADD:    return a + b;
			ex_pkg::ALU_SUB:    return a - b;
			ex_pkg::ALU_SLT:    return (as[`XLEN] != bs[`XLEN]) ? a[`XLEN-1] : a < b;
			ex_pkg::ALU_SLTU:   return a < b;
			ex_pkg::ALU_AND:    return a & b;
			ex_pkg::ALU_OR:     return a | b;
			ex_pkg::ALU_XOR:    return a ^ b;
			ex_pkg::ALU_SLL:    return a << sh;
			ex_pkg::ALU_SRL:    return a >> sh;
			ex_pkg::ALU_SRA:    return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
			ex_pkg::ALU_MUL:    return as * bs; // low half of the wide product
			ex_pkg::ALU_MULH:   return (as * bs) >> `XLEN;
			ex_pkg::ALU_MULHSU: return (as * bz) >> `XLEN;
			ex_pkg::ALU_MULHU:  return (az * bz) >> `XLEN;
			default:            return '0;
		endcase
	endfunction

	// operand b from the rv32 immediate formats
	function automatic logic [`XLEN-1:0] opb_model(int sel, logic [`XLEN-1:0] i,
		logic [`XLEN-1:0] b);
		case (sel)
			1: return {{20{i[31]}}, i[31:20]};
			2: return {{20{i[31]}}, i[31:25], i[11:7]};
			3: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
			4: return {i[31:12], 12'h000};
			5: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			default: return b; // rs2
		endcase
	endfunction

	function automatic logic branch_model(logic [2:0] f3, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b, logic c, logic u);
		logic lt, ltu;
		ltu = a < b;
		lt  = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : ltu; // signed via sign bits
		case (f3)
			3'b000:  return u | (c & (a == b));
			3'b001:  return u | (c & (a != b));
			3'b100:  return u | (c & lt);
			3'b101:  return u | (c & !lt);
			3'b110:  return u | (c & ltu);
			3'b111:  return u | (c & !ltu);
			default: return u; // not a branch code
		endcase
	endfunction

	//////////////////////////////////////////////////
	// checkers
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		fired = valid_out; // completions of the cycle just ended
		#1;
		for (int k = 0; k < `WAYS; k++) begin
			if (fired[k] === 1'b1 && exp_q[k].size() != 0) begin
				void'(exp_q[k].pop_front());
				void'(name_q[k].pop_front());
				refresh_head(k);
			end
		end
	end

	for (genvar i = 0; i < `WAYS; i++) begin : g_chk
		a_result: assert property (@(posedge clock) disable iff (reset)
			valid_out[i] && exp_pending[i] |-> alu_result[i*`XLEN +: `XLEN] == exp_head[i])
			else begin
				value_errs++;
				$display("ERR %s lane %0d: expected %h, actual %h", name_head[i], i,
					exp_head[i], $sampled(alu_result[i*`XLEN +: `XLEN]));
			end
		a_no_spurious: assert property (@(posedge clock) disable iff (reset)
			valid_out[i] |-> exp_pending[i] && !lq_cdb_valid[i])
			else begin
				proto_errs++;
				$display("lane %0d raised valid_out with nothing due or the bus taken", i);
			end
		a_int_same_cycle: assert property (@(posedge clock) disable iff (reset)
			valid[i] && !is_mult_code(alu_func[i*FW +: FW]) && !lq_cdb_valid[i]
			&& !occupied[i] |-> valid_out[i])
			else begin
				proto_errs++;
				$display("lane %0d gave no same-cycle valid_out for an integer op", i);
			end
		a_branch: assert property (@(posedge clock) disable iff (reset)
			br_check[i] |-> take_branch[i] == exp_br[i])
			else begin
				value_errs++;
				$display("ERR branch lane %0d: expected %b, actual %b", i, exp_br[i],
					$sampled(take_branch[i]));
			end
		a_occ_enter: assert property (@(posedge clock) disable iff (reset)
			valid[i] && is_mult_code(alu_func[i*FW +: FW]) && !lq_cdb_valid[i]
			&& !occupied[i] |=> occupied[i])
			else begin
				proto_errs++;
				$display("lane %0d did not go occupied on an accepted multiply", i);
			end
		a_occ_hold: assert property (@(posedge clock) disable iff (reset)
			occupied[i] && !valid_out[i] |=> occupied[i])
			else begin
				proto_errs++;
				$display("lane %0d dropped occupied before its multiply completed", i);
			end
		a_occ_idle: assert property (@(posedge clock) disable iff (reset)
			!exp_pending[i] |-> !occupied[i])
			else begin
				proto_errs++;
				$display("lane %0d occupied with no multiply outstanding", i);
			end
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the run hung", TIMEOUT_NS);
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		logic [`XLEN-1:0]  a, b, ins, p;
		logic [FW-1:0]     f;
		ex_pkg::alu_func_e fe;
		logic [`XLEN-1:0]  edges [4];
		edges = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h7fff_ffff};
		clock = 1'b0;
		reset = 1'b1;
		{valid, cond_branch, uncond_branch, lq_cdb_valid, br_check, exp_br} = '0;
		{alu_func, opa_select, opb_select} = '0;
		{inst, pc, npc, rs1_value, rs2_value} = '0;
		exp_pending = '0;
		value_errs = 0;
		proto_errs = 0;
		repeat (3) @(posedge clock);
		#2 reset = 1'b0;
		repeat (6) next_cycle(); // idle lanes stay quiet

		// integer ops with the lanes on different functions
		for (int fi = 0; fi < 10; fi++) begin
			for (int r = 0; r < INT_REPS; r++) begin
				for (int ln = 0; ln < `WAYS; ln++) begin
					f = FW'((fi + ln + r) % 10);
					fe = ex_pkg::alu_func_e'(f);
					a = rand_bits(32);
					b = rand_bits(32);
					set_lane(ln, f, 2'd0, 3'd0, rand_bits(32), rand_bits(32), a, b);
					push_expect(ln, alu_model(f, a, b), $sformatf("int_ops %s", fe.name()));
				end
				issue('1);
				wait_idle("int_ops");
			end
		end

		// every operand select through ADD
		for (int sa = 0; sa < 4; sa++) begin
			for (int sb = 0; sb < 6; sb++) begin
				for (int ln = 0; ln < `WAYS; ln++) begin
					a = rand_bits(32);
					b = rand_bits(32);
					ins = rand_bits(32);
					p = {rand_bits(30), 2'b00}; // word aligned pc
					set_lane(ln, ex_pkg::ALU_ADD, 2'(sa), 3'(sb), ins, p, a, b);
					push_expect(ln, (sa == 0 ? a : sa == 1 ? p + 4 : sa == 2 ? p : '0)
						+ opb_model(sb, ins, b), $sformatf("operand_sel a%0d b%0d", sa, sb));
				end
				issue('1);
				wait_idle("operand_sel");
			end
		end

		// branch conditions then uncond alone and neither
		for (int t = 0; t < 18; t++) begin
			for (int ln = 0; ln < `WAYS; ln++) begin
				a = rand_bits(32);
				b = (t % 2 == 0) ? a : rand_bits(32); // equal half the time
				ins = rand_bits(32);
				ins[14:12] = 3'(t / 2);
				set_lane(ln, ex_pkg::ALU_ADD, 2'd0, 3'd0, ins, '0, a, b);
				cond_branch[ln]   = t < 16;
				uncond_branch[ln] = t == 16;
				exp_br[ln] = branch_model(ins[14:12], a, b, t < 16, t == 16);
			end
			br_check = '1;
			next_cycle();
		end
		{br_check, cond_branch, uncond_branch} = '0;

		// multiplies with edge operands on lane 0 and random ones on lane 1
		for (int fi = 0; fi < 4; fi++) begin
			for (int k = 0; k < MULT_REPS; k++) begin
				f = FW'(ex_pkg::ALU_MUL + fi);
				fe = ex_pkg::alu_func_e'(f);
				for (int ln = 0; ln < `WAYS; ln++) begin
					a = (ln == 0) ? edges[k % 4] : rand_bits(32);
					b = (ln == 0) ? edges[(k / 4 + k) % 4] : rand_bits(32);
					set_lane(ln, f, 2'd0, 3'd0, rand_bits(32), '0, a, b);
					push_expect(ln, alu_model(f, a, b), $sformatf("mult %s", fe.name()));
				end
				issue('1);
				wait_idle("mult");
			end
		end

		// bus stall refuses the lane 0 multiply and holds lane 1 past done
		a = edges[0];
		b = rand_bits(32);
		lq_cdb_valid = 2'b01;
		set_lane(0, ex_pkg::ALU_MUL, 2'd0, 3'd0, rand_bits(32), '0, rand_bits(32), b);
		set_lane(1, ex_pkg::ALU_MULH, 2'd0, 3'd0, rand_bits(32), '0, a, b);
		push_expect(1, alu_model(ex_pkg::ALU_MULH, a, b), "cdb_stall MULH");
		issue(2'b11);
		lq_cdb_valid = 2'b11;
		repeat (`MULT_CYCLES + 4) next_cycle(); // result held back after done
		lq_cdb_valid = 2'b00;
		wait_idle("cdb_stall");
		repeat (4) next_cycle();

		$display("error counts: %0d wrong values, %0d protocol failures", value_errs,
			proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
